// ==== ram_writer_defines.svh ====
`ifndef RAM_WRITER_DEFINES_SVH
`define RAM_WRITER_DEFINES_SVH

// Width of the beat index
// The write address wraps after 2**RAM_ADDR_WIDTH beats
`define RAM_ADDR_WIDTH 20

// Byte address of beat index 0
`define RAM_ADDR_BASE 32'h1E000000

// Beats per AXI3 burst
// awlen carries this value minus one
`define BURST_BEATS 16

// Default FIFO depth as a power of two (64 beats)
// Must hold at least one full burst
`define FIFO_DEPTH_LOG2 6

// The writer derives wlast from the low index bits
// so BURST_BEATS stays a power of two

`endif

// ==== axi_pkg.sv ====
`default_nettype none

package axi_pkg;

  // Field widths of the AXI3 write channels
  localparam int AXI_ID_W    = 6;
  localparam int AXI_ADDR_W  = 32;
  localparam int AXI_DATA_W  = 64;
  localparam int AXI_STRB_W  = AXI_DATA_W / 8;
  localparam int AXI_LEN_W   = 4;              // AXI3 burst length field
  localparam int AXI_SIZE_W  = 3;
  localparam int AXI_BURST_W = 2;
  localparam int AXI_CACHE_W = 4;

  // Byte offset bits of one full-width beat
  localparam int AXI_ADDR_LSB = $clog2(AXI_STRB_W);

  // Burst type
  localparam logic [AXI_BURST_W-1:0] BURST_INCR = 2'b01;

  // Memory type, bufferable and modifiable
  localparam logic [AXI_CACHE_W-1:0] CACHE_BUFFERABLE_MODIFIABLE = 4'b0011;

  // Transfer size
  localparam logic [AXI_SIZE_W-1:0] SIZE_8_BYTES = 3'b011;

endpackage

`default_nettype wire

// ==== stream_pkg.sv ====
`default_nettype none

package stream_pkg;

  localparam int SAMPLE_W = 32;
  localparam int BEAT_W   = 2 * SAMPLE_W;

  // One sample of the input stream
  typedef logic [SAMPLE_W-1:0] sample_t;

  // Two samples in one memory beat, low sample first
  typedef struct packed {
    sample_t hi;                  // Second sample of the pair
    sample_t lo;                  // First sample of the pair
  } beat_halves_t;

  // A memory beat seen as a sample pair or as raw write data
  typedef union packed {
    beat_halves_t       halves;
    logic [BEAT_W-1:0]  word;
  } beat_u;

endpackage

`default_nettype wire

// ==== burst_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface burst_if
  import stream_pkg::*;
();

  beat_u rd_beat;                 // Head entry of the FIFO
  logic  rd_valid;                // FIFO not empty
  logic  burst_avail;             // At least one full burst stored
  logic  rd_pop;                  // One strobe per consumed beat

  modport fifo_side (
    output rd_beat,
    output rd_valid,
    output burst_avail,
    input  rd_pop
  );

  modport writer_side (
    input  rd_beat,
    input  rd_valid,
    input  burst_avail,
    output rd_pop
  );

endinterface

`default_nettype wire

// ==== sample_packer.sv ====
`timescale 1ns/1ns
`default_nettype none

module sample_packer
  import stream_pkg::*;
(
  input  wire     aclk,
  input  wire     aresetn,
  input  wire     sample_t tdata,
  input  wire     tvalid,
  output logic    tready,
  output logic    beat_valid,
  output beat_u   beat,
  input  wire     beat_ready
);

  logic half_q;                   // Low sample of the pair is held
  logic t_fire;

  // Stall only while a finished beat cannot leave
  assign tready = ~(beat_valid & ~beat_ready);
  assign t_fire = tvalid & tready;

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      half_q     <= 1'b0;
      beat_valid <= 1'b0;
    end
    else
    begin
      if (t_fire)
        half_q <= ~half_q;
      if (t_fire && half_q)
        beat_valid <= 1'b1;       // Pair complete
      else if (beat_ready)
        beat_valid <= 1'b0;       // Beat taken by the FIFO
    end
  end

  // The low half is only written once the previous beat is gone
  always_ff @(posedge aclk)
  begin
    if (t_fire)
    begin
      if (half_q)
        beat.halves.hi <= tdata;
      else
        beat.halves.lo <= tdata;
    end
  end

endmodule

`default_nettype wire

// ==== beat_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "ram_writer_defines.svh"

module beat_fifo
  import stream_pkg::*;
#(
  parameter int DEPTH_LOG2 = 6
)
(
  input  wire      aclk,
  input  wire      aresetn,
  input  wire      in_valid,
  input  wire      beat_u in_beat,
  output logic     in_ready,
  burst_if.fifo_side rd
);

  localparam int DEPTH = 1 << DEPTH_LOG2;

  localparam logic [DEPTH_LOG2:0] FULL_COUNT  = DEPTH[DEPTH_LOG2:0];
  localparam logic [DEPTH_LOG2:0] BURST_COUNT = (DEPTH_LOG2 + 1)'(`BURST_BEATS);

  beat_u mem [DEPTH];

  logic [DEPTH_LOG2-1:0] wr_ptr;
  logic [DEPTH_LOG2-1:0] rd_ptr;
  logic [DEPTH_LOG2:0]   count;   // Stored beats
  logic push;
  logic pop;

  assign push = in_valid & in_ready;
  assign pop  = rd.rd_pop & rd.rd_valid;

  // Status flags straight from the count
  assign in_ready       = (count != FULL_COUNT);
  assign rd.rd_valid    = (count != '0);
  assign rd.burst_avail = (count >= BURST_COUNT);
  assign rd.rd_beat     = mem[rd_ptr];

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Idle or push with pop
      endcase
    end
  end

  // Storage
  always_ff @(posedge aclk)
  begin
    if (push)
      mem[wr_ptr] <= in_beat;
  end

endmodule

`default_nettype wire

// ==== burst_writer.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "ram_writer_defines.svh"

module burst_writer
  import axi_pkg::*;
  import stream_pkg::*;
(
  input  wire  aclk,
  input  wire  aresetn,

  burst_if.writer_side rd,

  output logic [AXI_ID_W-1:0]    awid,
  output logic [AXI_ADDR_W-1:0]  awaddr,
  output logic [AXI_LEN_W-1:0]   awlen,
  output logic [AXI_SIZE_W-1:0]  awsize,
  output logic [AXI_BURST_W-1:0] awburst,
  output logic [AXI_CACHE_W-1:0] awcache,
  output logic                   awvalid,
  input  wire                    awready,

  output logic [AXI_ID_W-1:0]    wid,
  output logic [AXI_DATA_W-1:0]  wdata,
  output logic [AXI_STRB_W-1:0]  wstrb,
  output logic                   wlast,
  output logic                   wvalid,
  input  wire                    wready,

  output logic                   bready
);

  localparam int BURST_LSB = $clog2(`BURST_BEATS);

  logic                       awvalid_q;
  logic                       wvalid_q;
  logic [AXI_ID_W-1:0]        id_q;       // ID of the burst in flight
  logic [`RAM_ADDR_WIDTH-1:0] index_q;    // Beat index of the next W beat
  logic [AXI_ID_W-1:0]        aw_id_q;
  logic [AXI_ADDR_W-1:0]      aw_addr_q;

  logic start;
  logic aw_fire;
  logic w_fire;

  // The stored burst is complete, so AW and W go out together
  assign start   = ~awvalid_q & ~wvalid_q & rd.burst_avail & rd.rd_valid;
  assign aw_fire = awvalid_q & awready;
  assign w_fire  = wvalid_q & wready;
  assign wlast   = &index_q[BURST_LSB-1:0];

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      awvalid_q <= 1'b0;
      wvalid_q  <= 1'b0;
      id_q      <= '0;
      index_q   <= '0;
    end
    else
    begin
      if (start)
      begin
        awvalid_q <= 1'b1;
        wvalid_q  <= 1'b1;
      end
      else
      begin
        if (aw_fire)
          awvalid_q <= 1'b0;
        if (w_fire && wlast)
          wvalid_q <= 1'b0;           // Burst done, idle for one cycle
      end
      if (w_fire)
        index_q <= index_q + 1'b1;    // Wraps after 2**RAM_ADDR_WIDTH beats
      if (w_fire && wlast)
        id_q <= id_q + 1'b1;          // Arm the next burst
    end
  end

  // AW payload is captured at start and holds while W beats advance the index
  always_ff @(posedge aclk)
  begin
    if (start)
    begin
      aw_id_q   <= id_q;
      aw_addr_q <= AXI_ADDR_W'(`RAM_ADDR_BASE)
                 + AXI_ADDR_W'({index_q, {AXI_ADDR_LSB{1'b0}}});
    end
  end

  assign awid    = aw_id_q;
  assign awaddr  = aw_addr_q;
  assign awlen   = AXI_LEN_W'(`BURST_BEATS - 1);
  assign awsize  = SIZE_8_BYTES;
  assign awburst = BURST_INCR;
  assign awcache = CACHE_BUFFERABLE_MODIFIABLE;
  assign awvalid = awvalid_q;

  assign wid     = id_q;
  assign wdata   = rd.rd_beat.word;   // FIFO head goes straight out
  assign wstrb   = '1;
  assign wvalid  = wvalid_q;
  assign rd.rd_pop = w_fire;

  assign bready  = 1'b1;              // Responses are not checked

endmodule

`default_nettype wire

// ==== ram_writer_top.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "ram_writer_defines.svh"

module ram_writer_top
  import axi_pkg::*;
  import stream_pkg::*;
(
  input  wire                    aclk,
  input  wire                    aresetn,

  // Sample stream
  input  wire sample_t           tdata,
  input  wire                    tvalid,
  output wire                    tready,

  // AXI3 write address
  output wire [AXI_ID_W-1:0]     awid,
  output wire [AXI_ADDR_W-1:0]   awaddr,
  output wire [AXI_LEN_W-1:0]    awlen,
  output wire [AXI_SIZE_W-1:0]   awsize,
  output wire [AXI_BURST_W-1:0]  awburst,
  output wire [AXI_CACHE_W-1:0]  awcache,
  output wire                    awvalid,
  input  wire                    awready,

  // AXI3 write data and response
  output wire [AXI_ID_W-1:0]     wid,
  output wire [AXI_DATA_W-1:0]   wdata,
  output wire [AXI_STRB_W-1:0]   wstrb,
  output wire                    wlast,
  output wire                    wvalid,
  input  wire                    wready,
  output wire                    bready
);

  wire   beat_valid;
  wire   beat_ready;
  beat_u beat;

  burst_if burst_i ();

  sample_packer packer_i (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .tdata      (tdata),
    .tvalid     (tvalid),
    .tready     (tready),
    .beat_valid (beat_valid),
    .beat       (beat),
    .beat_ready (beat_ready)
  );

  beat_fifo #(.DEPTH_LOG2(`FIFO_DEPTH_LOG2)) fifo_i (
    .aclk (aclk), .aresetn (aresetn), .in_valid (beat_valid),
    .in_beat (beat), .in_ready (beat_ready), .rd (burst_i.fifo_side)
  );

  burst_writer writer_i (
    .aclk (aclk), .aresetn (aresetn), .rd (burst_i.writer_side),
    .awid (awid), .awaddr (awaddr), .awlen (awlen), .awsize (awsize),
    .awburst (awburst), .awcache (awcache), .awvalid (awvalid), .awready (awready),
    .wid (wid), .wdata (wdata), .wstrb (wstrb), .wlast (wlast),
    .wvalid (wvalid), .wready (wready), .bready (bready)
  );

endmodule

`default_nettype wire

// ==== axi_mem_model.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "ram_writer_defines.svh"

module axi_mem_model
  import axi_pkg::*;
(
  input  wire                    aclk,
  input  wire                    aresetn,
  input  wire                    aw_en,      // Ready enables from the testbench
  input  wire                    w_en,
  input  wire [AXI_ID_W-1:0]     awid,
  input  wire [AXI_ADDR_W-1:0]   awaddr,
  input  wire [AXI_LEN_W-1:0]    awlen,
  input  wire [AXI_SIZE_W-1:0]   awsize,
  input  wire [AXI_BURST_W-1:0]  awburst,
  input  wire [AXI_CACHE_W-1:0]  awcache,
  input  wire                    awvalid,
  output wire                    awready,
  input  wire [AXI_ID_W-1:0]     wid,
  input  wire [AXI_DATA_W-1:0]   wdata,
  input  wire                    wlast,
  input  wire                    wvalid,
  output wire                    wready
);

  localparam int MAX_BURSTS = 64;
  localparam int MAX_BEATS  = MAX_BURSTS * `BURST_BEATS;

  logic [AXI_ADDR_W-1:0]  aw_addr [MAX_BURSTS];
  logic [AXI_ID_W-1:0]    aw_id [MAX_BURSTS];
  logic [AXI_LEN_W-1:0]   aw_len [MAX_BURSTS];
  logic [AXI_SIZE_W-1:0]  aw_size [MAX_BURSTS];
  logic [AXI_BURST_W-1:0] aw_burst [MAX_BURSTS];
  logic [AXI_CACHE_W-1:0] aw_cache [MAX_BURSTS];
  logic [AXI_DATA_W-1:0]  w_data [MAX_BEATS];
  logic [AXI_ID_W-1:0]    w_id [MAX_BEATS];
  logic                   w_last [MAX_BEATS];
  logic [AXI_DATA_W-1:0]  mem [logic [AXI_ADDR_W-1:0]];  // Byte address to beat

  int aw_count = 0;
  int w_count  = 0;
  int stored   = 0;                           // Beats placed at their address

  assign awready = aw_en;
  assign wready  = w_en;

  always @(posedge aclk)
  begin
    if (aresetn)
    begin
      if (awvalid && awready && aw_count < MAX_BURSTS)
      begin
        aw_addr[aw_count]  = awaddr;
        aw_id[aw_count]    = awid;
        aw_len[aw_count]   = awlen;
        aw_size[aw_count]  = awsize;
        aw_burst[aw_count] = awburst;
        aw_cache[aw_count] = awcache;
        aw_count++;
      end
      if (wvalid && wready && w_count < MAX_BEATS)
      begin
        w_data[w_count] = wdata;
        w_id[w_count]   = wid;
        w_last[w_count] = wlast;
        w_count++;
      end
      // W may run ahead of AW, so beats land once their burst address is known
      while (stored < w_count && stored / `BURST_BEATS < aw_count)
      begin
        mem[aw_addr[stored / `BURST_BEATS] + AXI_ADDR_W'(8 * (stored % `BURST_BEATS))] =
          w_data[stored];
        stored++;
      end
    end
  end

endmodule

`default_nettype wire

// ==== ram_writer_properties.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "ram_writer_defines.svh"

module ram_writer_properties
  import axi_pkg::*;
(
  input wire                  aclk,
  input wire                  aresetn,
  input wire                  awvalid,
  input wire                  awready,
  input wire [AXI_ID_W-1:0]   awid,
  input wire [AXI_ADDR_W-1:0] awaddr,
  input wire                  wvalid,
  input wire                  wready,
  input wire [AXI_ID_W-1:0]   wid,
  input wire [AXI_DATA_W-1:0] wdata,
  input wire                  wlast
);

  logic [$clog2(`BURST_BEATS)-1:0] beat_cnt;  // W handshakes within the burst

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
      beat_cnt <= '0;
    else if (wvalid && wready)
      beat_cnt <= beat_cnt + 1'b1;
  end

  aw_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    awvalid && !awready |=> awvalid && $stable(awaddr) && $stable(awid))
    else $error("awvalid dropped or AW payload changed before awready");

  w_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wlast) && $stable(wid))
    else $error("wvalid dropped or W payload changed before wready");

  last_beat: assert property (@(posedge aclk) disable iff (!aresetn)
    wvalid && wready |-> (wlast == (beat_cnt == '1)))
    else $error("wlast not on the sixteenth beat of a burst");

  aw_reset: assert property (@(posedge aclk) !aresetn |=> !awvalid)
    else $error("awvalid high during reset");

endmodule

`default_nettype wire

// ==== tb_ram_writer.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "ram_writer_defines.svh"

module tb_ram_writer
  import axi_pkg::*;
  import stream_pkg::*;
();

  localparam int TIMEOUT     = 5000;          // Cycles per wait loop
  localparam int STALL_LIMIT = 20;            // Stalled cycles before wready returns
  localparam int DEPTH       = 1 << `FIFO_DEPTH_LOG2;

  logic aclk;
  logic aresetn;
  sample_t tdata;
  logic tvalid;
  logic aw_en;
  logic w_en;
  logic rand_ready;
  logic stall_seen;
  wire  tready, awvalid, awready, wlast, wvalid, wready, bready;
  wire [AXI_ID_W-1:0]    awid, wid;
  wire [AXI_ADDR_W-1:0]  awaddr;
  wire [AXI_LEN_W-1:0]   awlen;
  wire [AXI_SIZE_W-1:0]  awsize;
  wire [AXI_BURST_W-1:0] awburst;
  wire [AXI_CACHE_W-1:0] awcache;
  wire [AXI_DATA_W-1:0]  wdata;
  wire [AXI_STRB_W-1:0]  wstrb;

  int unsigned seed_data  = 6447;
  int unsigned seed_ready = 6447;
  int mismatches = 0;
  int failures   = 0;
  int count      = 0;                         // Counting sample value
  sample_t exp_q[$];                          // Every accepted sample in order

  ram_writer_top dut_i (.*);

  axi_mem_model mem_i (
    .aclk (aclk), .aresetn (aresetn), .aw_en (aw_en), .w_en (w_en),
    .awid (awid), .awaddr (awaddr), .awlen (awlen), .awsize (awsize),
    .awburst (awburst), .awcache (awcache), .awvalid (awvalid), .awready (awready),
    .wid (wid), .wdata (wdata), .wlast (wlast), .wvalid (wvalid), .wready (wready)
  );

  bind burst_writer ram_writer_properties props_i (
    .aclk (aclk), .aresetn (aresetn), .awvalid (awvalid), .awready (awready),
    .awid (awid), .awaddr (awaddr), .wvalid (wvalid), .wready (wready),
    .wid (wid), .wdata (wdata), .wlast (wlast)
  );

  initial
  begin
    aclk = 1'b0;
    forever #2 aclk = ~aclk;
  end

  function automatic int unsigned lcg_next(input int unsigned s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Random ready pattern, active only in the back-pressure test
  always @(posedge aclk)
  begin
    #1;
    if (rand_ready)
    begin
      seed_ready = lcg_next(seed_ready);
      aw_en = seed_ready[20];
      w_en  = seed_ready[22] | seed_ready[23];
    end
  end

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp)
    else
    begin
      mismatches++;
      $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_true(input bit ok, input string what);
    assert (ok)
    else
    begin
      failures++;
      $display("error at %0t ns: %s", $time, what);
    end
  endtask

  // Full strobes on every data beat, responses always accepted
  always @(posedge aclk)
  begin
    if (aresetn && wvalid)
      check_value("wstrb", 64'(wstrb), 64'({AXI_STRB_W{1'b1}}));
    if (aresetn)
      check_value("bready", 64'(bready), 64'd1);
  end

  task automatic send_sample(input sample_t d, input bit rand_gap, input bit release_on_stall);
    int t;
    if (rand_gap)
    begin
      seed_data = lcg_next(seed_data);
      repeat (seed_data[17:16])
      begin
        @(posedge aclk);
        #1;
      end
    end
    tdata  = d;
    tvalid = 1'b1;
    t = 0;
    while (!tready && t < TIMEOUT)
    begin
      if (release_on_stall && t == STALL_LIMIT)
      begin
        stall_seen = 1'b1;
        w_en = 1'b1;                          // Let the writer drain again
      end
      @(posedge aclk);
      #1;
      t++;
    end
    check_true(tready, "stream sample was never accepted");
    @(posedge aclk);
    #1;
    tvalid = 1'b0;
    exp_q.push_back(d);
  endtask

  task automatic send_counting(input int n, input bit release_on_stall);
    repeat (n)
    begin
      send_sample(sample_t'(32'hC0DE0000 + count), 1'b0, release_on_stall);
      count++;
    end
  endtask

  task automatic wait_bursts(input int n);
    int t;
    t = 0;
    while ((mem_i.aw_count < n || mem_i.stored < n * `BURST_BEATS) && t < TIMEOUT)
    begin
      @(posedge aclk);
      #1;
      t++;
    end
    check_true(mem_i.stored >= n * `BURST_BEATS, "timeout waiting for burst completion");
  endtask

  // Beat k holds sample 2k in lo and sample 2k+1 in hi
  task automatic check_memory();
    beat_u b;
    logic [AXI_ADDR_W-1:0] addr;
    for (int k = 0; k < mem_i.stored; k++)
    begin
      addr = `RAM_ADDR_BASE + AXI_ADDR_W'((k % (1 << `RAM_ADDR_WIDTH)) * 8);
      check_true(mem_i.mem.exists(addr), $sformatf("no beat written at %h", addr));
      if (mem_i.mem.exists(addr) && 2 * k + 1 < exp_q.size())
      begin
        b.word = mem_i.mem[addr];
        check_value($sformatf("mem[%0d].lo", k), 64'(b.halves.lo), 64'(exp_q[2 * k]));
        check_value($sformatf("mem[%0d].hi", k), 64'(b.halves.hi), 64'(exp_q[2 * k + 1]));
      end
    end
  endtask

  // Address follows base plus beat index times 8, with the index wrapping
  task automatic check_bursts();
    logic [AXI_ADDR_W-1:0] exp_addr;
    for (int b = 0; b < mem_i.aw_count; b++)
    begin
      exp_addr = `RAM_ADDR_BASE
               + AXI_ADDR_W'(((b * `BURST_BEATS) % (1 << `RAM_ADDR_WIDTH)) * 8);
      check_value($sformatf("awaddr[%0d]", b), 64'(mem_i.aw_addr[b]), 64'(exp_addr));
      check_value($sformatf("awid[%0d]", b), 64'(mem_i.aw_id[b]), 64'(b % (1 << AXI_ID_W)));
      check_value("awlen", 64'(mem_i.aw_len[b]), 64'(`BURST_BEATS - 1));
      check_value("awsize", 64'(mem_i.aw_size[b]), 64'(SIZE_8_BYTES));
      check_value("awburst", 64'(mem_i.aw_burst[b]), 64'(BURST_INCR));
      check_value("awcache", 64'(mem_i.aw_cache[b]), 64'(CACHE_BUFFERABLE_MODIFIABLE));
    end
    for (int n = 0; n < mem_i.w_count; n++)
    begin
      check_value($sformatf("wlast[%0d]", n), 64'(mem_i.w_last[n]),
                  64'(n % `BURST_BEATS == `BURST_BEATS - 1));
      check_value($sformatf("wid[%0d]", n), 64'(mem_i.w_id[n]),
                  64'((n / `BURST_BEATS) % (1 << AXI_ID_W)));
    end
  endtask

  task automatic test_single_burst();
    send_counting(32, 1'b0);
    wait_bursts(1);
    check_value("aw_count", 64'(mem_i.aw_count), 64'd1);
    check_value("awaddr", 64'(mem_i.aw_addr[0]), 64'(`RAM_ADDR_BASE));
    check_value("awid", 64'(mem_i.aw_id[0]), 64'd0);
    check_value("awlen", 64'(mem_i.aw_len[0]), 64'd15);
    check_value("awsize", 64'(mem_i.aw_size[0]), 64'd3);        // 8 bytes per beat
    check_value("awburst", 64'(mem_i.aw_burst[0]), 64'd1);      // INCR
    check_value("awcache", 64'(mem_i.aw_cache[0]), 64'b0011);
    check_memory();
  endtask

  task automatic test_partial_hold();
    send_counting(30, 1'b0);
    repeat (200)
    begin
      @(posedge aclk);
      #1;
      check_value("aw_count while partial", 64'(mem_i.aw_count), 64'd1);
    end
    send_counting(2, 1'b0);
    wait_bursts(2);
    check_memory();
  endtask

  task automatic test_consecutive();
    send_counting(96, 1'b0);
    wait_bursts(5);
    check_bursts();
    check_memory();
  endtask

  task automatic test_random_ready();
    rand_ready = 1'b1;
    repeat (128)
    begin
      seed_data = lcg_next(seed_data);
      send_sample(sample_t'(seed_data), 1'b1, 1'b0);
    end
    wait_bursts(9);
    rand_ready = 1'b0;
    #4;
    aw_en = 1'b1;
    w_en  = 1'b1;
    check_memory();
  endtask

  task automatic test_fifo_full();
    w_en = 1'b0;
    stall_seen = 1'b0;
    send_counting(2 * DEPTH + 2 * `BURST_BEATS, 1'b1);
    check_true(stall_seen, "tready never dropped with the FIFO full");
    wait_bursts(14);
    check_memory();
  endtask

  task automatic test_address_rule();
    send_counting(4 * `BURST_BEATS, 1'b0);
    wait_bursts(16);
    check_bursts();
    check_memory();
  endtask

  initial
  begin
    aresetn = 1'b0;
    tdata = '0;
    tvalid = 1'b0;
    aw_en = 1'b1;
    w_en = 1'b1;
    rand_ready = 1'b0;
    stall_seen = 1'b0;
    repeat (10) @(posedge aclk);
    #1;
    aresetn = 1'b1;
    test_single_burst();
    test_partial_hold();
    test_consecutive();
    test_random_ready();
    test_fifo_full();
    test_address_rule();
    $display("checks done: %0d mismatches, %0d other errors", mismatches, failures);
    if (mismatches == 0 && failures == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+.
axi_pkg.sv
stream_pkg.sv
burst_if.sv
sample_packer.sv
beat_fifo.sv
burst_writer.sv
ram_writer_top.sv
axi_mem_model.sv
ram_writer_properties.sv
tb_ram_writer.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_ram_writer
FILELIST  := tb.f

SOURCES := $(shell grep -v '^+' $(FILELIST)) ram_writer_defines.svh
BIN     := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir
